// File: design/err_resp_pkg.sv
// ------------------------------------------------
// Widths, CSR map and encodings shared by the
// DECERR target RTL and its testbench
// ------------------------------------------------
package err_resp_pkg;
    // AXI3 field widths
    localparam int ID_W    = 4;
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int LEN_W   = 4;
    localparam int SIZE_W  = 3;
    localparam int BURST_W = 2;
    localparam int PROT_W  = 3;
    localparam int RESP_W  = 2;
    localparam logic [RESP_W-1:0] RESP_DECERR = 2'b11;

    // Per-direction error log
    localparam int LOG_DEPTH = 4;
    localparam int LOG_PTR_W = $clog2(LOG_DEPTH);

    // CSR word offsets
    localparam int CSR_ADDR_W = 12;
    localparam logic [CSR_ADDR_W-1:0] CSR_INTR_STS = 12'h000;
    localparam logic [CSR_ADDR_W-1:0] CSR_R_INFO   = 12'h100;
    localparam logic [CSR_ADDR_W-1:0] CSR_R_ID     = 12'h104;
    localparam logic [CSR_ADDR_W-1:0] CSR_R_ADDR   = 12'h108;
    localparam logic [CSR_ADDR_W-1:0] CSR_W_INFO   = 12'h190;
    localparam logic [CSR_ADDR_W-1:0] CSR_W_ID     = 12'h194;
    localparam logic [CSR_ADDR_W-1:0] CSR_W_ADDR   = 12'h198;
    localparam logic [CSR_ADDR_W-1:0] CSR_W_WDATA  = 12'h1A0;

    // INFO word layout
    localparam int INFO_VALID     = 0;
    localparam int INFO_PROT_LSB  = 1;
    localparam int INFO_SIZE_LSB  = 4;
    localparam int INFO_LEN_LSB   = 7;
    localparam int INFO_BURST_LSB = 11;

    // INTR_STS bits
    localparam int INTR_BITS   = 4;
    localparam int INTR_WR     = 0;
    localparam int INTR_RD     = 1;
    localparam int INTR_WR_OVF = 2;
    localparam int INTR_RD_OVF = 3;

    // Response FSM states
    localparam int ST_W = 2;
    localparam logic [ST_W-1:0] ST_IDLE = 2'd0;
    localparam logic [ST_W-1:0] ST_DATA = 2'd1;
    localparam logic [ST_W-1:0] ST_RESP = 2'd2;
endpackage

// File: design/err_log_if.sv
// ------------------------------------------------
// One error log link: channel pushes entries,
// CSR bank pops them and sees the head
// ------------------------------------------------
interface err_log_if import err_resp_pkg::*; ();
    // Push side, driven by the response FSM
    logic               load;
    logic [ID_W-1:0]    id;
    logic [ADDR_W-1:0]  addr;
    logic [LEN_W-1:0]   len;
    logic [SIZE_W-1:0]  size;
    logic [BURST_W-1:0] burst;
    logic [PROT_W-1:0]  prot;
    logic [DATA_W-1:0]  data;

    // Pop side
    logic               unload;
    logic               not_empty;
    logic               overflow;
    logic [ID_W-1:0]    h_id;
    logic [ADDR_W-1:0]  h_addr;
    logic [LEN_W-1:0]   h_len;
    logic [SIZE_W-1:0]  h_size;
    logic [BURST_W-1:0] h_burst;
    logic [PROT_W-1:0]  h_prot;
    logic [DATA_W-1:0]  h_data;

    modport channel (output load, id, addr, len, size, burst, prot, data);

    modport log (
        input  load, id, addr, len, size, burst, prot, data, unload,
        output not_empty, overflow, h_id, h_addr, h_len, h_size, h_burst, h_prot, h_data
    );

    modport csr (
        input  load, not_empty, overflow, h_id, h_addr, h_len, h_size, h_burst, h_prot,
        input  h_data,
        output unload
    );
endinterface

// File: design/burst_beat_counter.sv
// ------------------------------------------------
// Read burst beat counter, flags the final R beat
// ------------------------------------------------
module burst_beat_counter import err_resp_pkg::*; (
    input  logic             aclk,
    input  logic             aresetn,
    input  logic             i_load,
    input  logic [LEN_W-1:0] i_len,
    input  logic             i_step,
    output logic             o_last
);
    logic [LEN_W-1:0] count;
    logic             active;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            count  <= '0;
            active <= 1'b0;
        end else if (i_load) begin
            // Beats left after the current one
            count  <= i_len;
            active <= 1'b1;
        end else if (i_step) begin
            if (count == '0) begin
                active <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    assign o_last = active && (count == '0);

    // No R transfer outside a burst
    a_step_in_burst: assert property (@(posedge aclk) disable iff (!aresetn)
        i_step && !i_load |-> active);

endmodule

// File: design/axi_err_resp_fsm.sv
// ------------------------------------------------
// One AXI direction of the DECERR target.
// IS_READ=0 runs AW/W/B, IS_READ=1 runs AR/R
// ------------------------------------------------
module axi_err_resp_fsm import err_resp_pkg::*; #(
    parameter bit IS_READ = 1'b0
) (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               i_a_valid,
    input  logic [ID_W-1:0]    i_a_id,
    input  logic [ADDR_W-1:0]  i_a_addr,
    input  logic [LEN_W-1:0]   i_a_len,
    input  logic [SIZE_W-1:0]  i_a_size,
    input  logic [BURST_W-1:0] i_a_burst,
    input  logic [PROT_W-1:0]  i_a_prot,
    input  logic               i_w_valid,
    input  logic [DATA_W-1:0]  i_w_data,
    input  logic               i_w_last,
    input  logic               i_o_ready,
    output logic               o_a_ready,
    output logic               o_w_ready,
    output logic               o_o_valid,
    output logic [ID_W-1:0]    o_o_id,
    output logic               o_o_last,
    output logic [RESP_W-1:0]  o_o_resp,
    err_log_if.channel         log
);
    logic [ST_W-1:0] state;
    logic            a_fire;
    logic            w_last_fire;
    logic            o_fire;

    assign a_fire      = i_a_valid & o_a_ready;
    assign w_last_fire = i_w_valid & o_w_ready & i_w_last;
    assign o_fire      = o_o_valid & i_o_ready;

    // Every transaction ends in DECERR
    assign o_o_resp = RESP_DECERR;

    // ------------------------------------------------
    // Handshake FSM
    // ------------------------------------------------
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state     <= ST_IDLE;
            o_a_ready <= 1'b0;
            o_w_ready <= 1'b0;
            o_o_valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (a_fire) begin
                        o_a_ready <= 1'b0;
                        // Reads answer right away, writes wait for data
                        o_w_ready <= !IS_READ;
                        o_o_valid <= IS_READ;
                        state     <= IS_READ ? ST_RESP : ST_DATA;
                    end else begin
                        // Raised on the first edge out of reset
                        o_a_ready <= 1'b1;
                    end
                end
                ST_DATA: begin
                    if (w_last_fire) begin
                        o_w_ready <= 1'b0;
                        o_o_valid <= 1'b1;
                        state     <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    // Single B beat, or final R beat
                    if (o_fire && o_o_last) begin
                        o_o_valid <= 1'b0;
                        o_a_ready <= 1'b1;
                        state     <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Response id
    always_ff @(posedge aclk) begin
        if (a_fire) begin
            o_o_id <= i_a_id;
        end
    end

    // ------------------------------------------------
    // Log push
    // ------------------------------------------------
    if (IS_READ) begin : g_read
        // Attributes straight off AR, logged on its transfer
        assign log.load  = a_fire;
        assign log.id    = i_a_id;
        assign log.addr  = i_a_addr;
        assign log.len   = i_a_len;
        assign log.size  = i_a_size;
        assign log.burst = i_a_burst;
        assign log.prot  = i_a_prot;

        // Beat count gives rlast
        burst_beat_counter beat_cnt_i (
            .aclk    (aclk),
            .aresetn (aresetn),
            .i_load  (a_fire),
            .i_len   (i_a_len),
            .i_step  (o_fire),
            .o_last  (o_o_last)
        );
    end else begin : g_write
        logic [ADDR_W-1:0]  addr_q;
        logic [LEN_W-1:0]   len_q;
        logic [SIZE_W-1:0]  size_q;
        logic [BURST_W-1:0] burst_q;
        logic [PROT_W-1:0]  prot_q;

        // AW attributes held until wlast
        always_ff @(posedge aclk) begin
            if (a_fire) begin
                addr_q  <= i_a_addr;
                len_q   <= i_a_len;
                size_q  <= i_a_size;
                burst_q <= i_a_burst;
                prot_q  <= i_a_prot;
            end
        end

        assign log.load  = w_last_fire;
        assign log.id    = o_o_id;
        assign log.addr  = addr_q;
        assign log.len   = len_q;
        assign log.size  = size_q;
        assign log.burst = burst_q;
        assign log.prot  = prot_q;
        // Last beat's data
        assign log.data  = i_w_data;

        // B is one beat
        assign o_o_last = o_o_valid;
    end

    // Stalled response must hold
    a_resp_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        o_o_valid && !i_o_ready |=>
            o_o_valid && $stable(o_o_id) && $stable(o_o_last) && $stable(o_o_resp));

    a_last_valid: assert property (@(posedge aclk) disable iff (!aresetn)
        o_o_last |-> o_o_valid);

endmodule

// File: design/err_log_fifo.sv
// ------------------------------------------------
// Log of rejected transactions, LOG_DEPTH deep.
// Head entry visible without a pop
// ------------------------------------------------
module err_log_fifo import err_resp_pkg::*; #(
    parameter bit STORE_DATA = 1'b1
) (
    input  logic  aclk,
    input  logic  aresetn,
    err_log_if.log log
);
    logic [ID_W-1:0]    mem_id    [LOG_DEPTH];
    logic [ADDR_W-1:0]  mem_addr  [LOG_DEPTH];
    logic [LEN_W-1:0]   mem_len   [LOG_DEPTH];
    logic [SIZE_W-1:0]  mem_size  [LOG_DEPTH];
    logic [BURST_W-1:0] mem_burst [LOG_DEPTH];
    logic [PROT_W-1:0]  mem_prot  [LOG_DEPTH];
    logic [LOG_PTR_W-1:0] wr_ptr;
    logic [LOG_PTR_W-1:0] rd_ptr;
    logic [LOG_PTR_W:0]   count;
    logic                 full;
    logic                 push;
    logic                 pop;

    assign full = (count == (LOG_PTR_W+1)'(LOG_DEPTH));
    // Loads into a full log are dropped
    assign push = log.load & ~full;
    assign pop  = log.unload & log.not_empty;

    assign log.not_empty = (count != '0);
    assign log.overflow  = log.load & full;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            mem_id[wr_ptr]    <= log.id;
            mem_addr[wr_ptr]  <= log.addr;
            mem_len[wr_ptr]   <= log.len;
            mem_size[wr_ptr]  <= log.size;
            mem_burst[wr_ptr] <= log.burst;
            mem_prot[wr_ptr]  <= log.prot;
        end
    end

    // Head entry
    assign log.h_id    = mem_id[rd_ptr];
    assign log.h_addr  = mem_addr[rd_ptr];
    assign log.h_len   = mem_len[rd_ptr];
    assign log.h_size  = mem_size[rd_ptr];
    assign log.h_burst = mem_burst[rd_ptr];
    assign log.h_prot  = mem_prot[rd_ptr];

    // Write log also keeps the last data beat
    if (STORE_DATA) begin : g_data
        logic [DATA_W-1:0] mem_data [LOG_DEPTH];

        always_ff @(posedge aclk) begin
            if (push) begin
                mem_data[wr_ptr] <= log.data;
            end
        end

        assign log.h_data = mem_data[rd_ptr];
    end

    a_count_bound: assert property (@(posedge aclk) disable iff (!aresetn)
        count <= (LOG_PTR_W+1)'(LOG_DEPTH));

endmodule

// File: design/err_csr_bank.sv
// ------------------------------------------------
// CSR port of the DECERR target: log readout,
// pop on last word, sticky W1C status and irq
// ------------------------------------------------
module err_csr_bank import err_resp_pkg::*; (
    input  logic                  aclk,
    input  logic                  aresetn,
    input  logic [CSR_ADDR_W-1:0] i_address,
    input  logic                  i_write,
    input  logic                  i_read,
    input  logic [DATA_W-1:0]     i_writedata,
    output logic [DATA_W-1:0]     o_readdata,
    output logic                  o_irq,
    err_log_if.csr                rd_log,
    err_log_if.csr                wr_log
);
    logic [INTR_BITS-1:0] sts;
    logic [INTR_BITS-1:0] sts_set;
    logic [INTR_BITS-1:0] sts_clr;
    logic [INTR_BITS-1:0] sts_nxt;
    logic [DATA_W-1:0]    rd_word;

    // INFO word, all zero once the log is empty
    function automatic logic [DATA_W-1:0] info_word(
        input logic               valid,
        input logic [PROT_W-1:0]  prot,
        input logic [SIZE_W-1:0]  size,
        input logic [LEN_W-1:0]   len,
        input logic [BURST_W-1:0] burst
    );
        logic [DATA_W-1:0] w;
        w = '0;
        if (valid) begin
            w[INFO_VALID]                  = 1'b1;
            w[INFO_PROT_LSB +: PROT_W]     = prot;
            w[INFO_SIZE_LSB +: SIZE_W]     = size;
            w[INFO_LEN_LSB +: LEN_W]       = len;
            w[INFO_BURST_LSB +: BURST_W]   = burst;
        end
        return w;
    endfunction

    // ------------------------------------------------
    // Read decode
    // ------------------------------------------------
    always_comb begin
        rd_word = '0;
        case (i_address)
            CSR_INTR_STS: rd_word[INTR_BITS-1:0] = sts;
            CSR_R_INFO: rd_word = info_word(rd_log.not_empty, rd_log.h_prot,
                                            rd_log.h_size, rd_log.h_len, rd_log.h_burst);
            CSR_R_ID: if (rd_log.not_empty) rd_word[ID_W-1:0] = rd_log.h_id;
            CSR_R_ADDR: if (rd_log.not_empty) rd_word = rd_log.h_addr;
            CSR_W_INFO: rd_word = info_word(wr_log.not_empty, wr_log.h_prot,
                                            wr_log.h_size, wr_log.h_len, wr_log.h_burst);
            CSR_W_ID: if (wr_log.not_empty) rd_word[ID_W-1:0] = wr_log.h_id;
            CSR_W_ADDR: if (wr_log.not_empty) rd_word = wr_log.h_addr;
            CSR_W_WDATA: if (wr_log.not_empty) rd_word = wr_log.h_data;
            // Unmapped offsets read zero
            default: rd_word = '0;
        endcase
    end

    // Last word of an entry pops it
    assign rd_log.unload = i_read && (i_address == CSR_R_ADDR);
    assign wr_log.unload = i_read && (i_address == CSR_W_WDATA);

    // ------------------------------------------------
    // Interrupt status, set wins over clear
    // ------------------------------------------------
    always_comb begin
        sts_set              = '0;
        sts_set[INTR_WR]     = wr_log.load | wr_log.not_empty;
        sts_set[INTR_RD]     = rd_log.load | rd_log.not_empty;
        sts_set[INTR_WR_OVF] = wr_log.overflow;
        sts_set[INTR_RD_OVF] = rd_log.overflow;
    end

    assign sts_clr = (i_write && (i_address == CSR_INTR_STS)) ?
                     i_writedata[INTR_BITS-1:0] : '0;
    assign sts_nxt = sts_set | (sts & ~sts_clr);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            sts        <= '0;
            o_irq      <= 1'b0;
            o_readdata <= '0;
        end else begin
            sts   <= sts_nxt;
            o_irq <= |sts_nxt;
            // Held until the next read
            if (i_read) begin
                o_readdata <= rd_word;
            end
        end
    end

    // Irq only rises after a log event
    a_irq_source: assert property (@(posedge aclk) disable iff (!aresetn)
        $rose(o_irq) |-> $past(|sts_set));

endmodule

// File: design/axi_err_slave.sv
// ------------------------------------------------
// Default AXI target: every access ends in DECERR
// and is logged for readout over the CSR port
// ------------------------------------------------
module axi_err_slave import err_resp_pkg::*; (
    input  logic                  aclk,
    input  logic                  aresetn,
    // Write address
    input  logic [ID_W-1:0]       i_awid,
    input  logic [ADDR_W-1:0]     i_awaddr,
    input  logic [LEN_W-1:0]      i_awlen,
    input  logic [SIZE_W-1:0]     i_awsize,
    input  logic [BURST_W-1:0]    i_awburst,
    input  logic [PROT_W-1:0]     i_awprot,
    input  logic                  i_awvalid,
    output logic                  o_awready,
    // Write data
    input  logic [DATA_W-1:0]     i_wdata,
    input  logic                  i_wlast,
    input  logic                  i_wvalid,
    output logic                  o_wready,
    // Write response
    output logic [ID_W-1:0]       o_bid,
    output logic [RESP_W-1:0]     o_bresp,
    output logic                  o_bvalid,
    input  logic                  i_bready,
    // Read address
    input  logic [ID_W-1:0]       i_arid,
    input  logic [ADDR_W-1:0]     i_araddr,
    input  logic [LEN_W-1:0]      i_arlen,
    input  logic [SIZE_W-1:0]     i_arsize,
    input  logic [BURST_W-1:0]    i_arburst,
    input  logic [PROT_W-1:0]     i_arprot,
    input  logic                  i_arvalid,
    output logic                  o_arready,
    // Read data
    output logic [ID_W-1:0]       o_rid,
    output logic [DATA_W-1:0]     o_rdata,
    output logic [RESP_W-1:0]     o_rresp,
    output logic                  o_rlast,
    output logic                  o_rvalid,
    input  logic                  i_rready,
    // CSR port
    input  logic [CSR_ADDR_W-1:0] i_av_address,
    input  logic                  i_av_write,
    input  logic                  i_av_read,
    input  logic [DATA_W-1:0]     i_av_writedata,
    output logic [DATA_W-1:0]     o_av_readdata,
    output logic                  o_irq
);
    err_log_if rd_log ();
    err_log_if wr_log ();

    // Error reads carry no data
    assign o_rdata = '0;

    axi_err_resp_fsm #(.IS_READ(1'b0)) wr_resp_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_a_valid (i_awvalid),
        .i_a_id    (i_awid),
        .i_a_addr  (i_awaddr),
        .i_a_len   (i_awlen),
        .i_a_size  (i_awsize),
        .i_a_burst (i_awburst),
        .i_a_prot  (i_awprot),
        .i_w_valid (i_wvalid),
        .i_w_data  (i_wdata),
        .i_w_last  (i_wlast),
        .i_o_ready (i_bready),
        .o_a_ready (o_awready),
        .o_w_ready (o_wready),
        .o_o_valid (o_bvalid),
        .o_o_id    (o_bid),
        .o_o_last  (),
        .o_o_resp  (o_bresp),
        .log       (wr_log)
    );

    // No W channel on the read side
    axi_err_resp_fsm #(.IS_READ(1'b1)) rd_resp_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_a_valid (i_arvalid),
        .i_a_id    (i_arid),
        .i_a_addr  (i_araddr),
        .i_a_len   (i_arlen),
        .i_a_size  (i_arsize),
        .i_a_burst (i_arburst),
        .i_a_prot  (i_arprot),
        .i_w_valid (1'b0),
        .i_w_data  ('0),
        .i_w_last  (1'b0),
        .i_o_ready (i_rready),
        .o_a_ready (o_arready),
        .o_w_ready (),
        .o_o_valid (o_rvalid),
        .o_o_id    (o_rid),
        .o_o_last  (o_rlast),
        .o_o_resp  (o_rresp),
        .log       (rd_log)
    );

    err_log_fifo #(.STORE_DATA(1'b1)) wr_log_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .log     (wr_log)
    );

    err_log_fifo #(.STORE_DATA(1'b0)) rd_log_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .log     (rd_log)
    );

    err_csr_bank csr_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_address   (i_av_address),
        .i_write     (i_av_write),
        .i_read      (i_av_read),
        .i_writedata (i_av_writedata),
        .o_readdata  (o_av_readdata),
        .o_irq       (o_irq),
        .rd_log      (rd_log),
        .wr_log      (wr_log)
    );

endmodule

// File: tests/tb_axi_err_slave.sv
// ------------------------------------------------
// Testbench for the DECERR target
// Drives random AXI errors and reads the log back
// over CSR, including status and overflow
// ------------------------------------------------
module tb_axi_err_slave import err_resp_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_BASIC     = 3;
    localparam int N_OVF       = 6;
    localparam int NUM_TRANS   = 2 * N_BASIC + 2 * N_OVF;
    localparam int TIMEOUT_CYC = 40 * NUM_TRANS + 2000;
    localparam logic [31:0] SEED = 32'h5bd6_2830;

    logic aclk, aresetn;
    logic [ID_W-1:0] i_awid, i_arid, o_bid, o_rid;
    logic [ADDR_W-1:0] i_awaddr, i_araddr;
    logic [LEN_W-1:0] i_awlen, i_arlen;
    logic [SIZE_W-1:0] i_awsize, i_arsize;
    logic [BURST_W-1:0] i_awburst, i_arburst;
    logic [PROT_W-1:0] i_awprot, i_arprot;
    logic i_awvalid, o_awready, i_wlast, i_wvalid, o_wready, o_bvalid, i_bready;
    logic i_arvalid, o_arready, o_rlast, o_rvalid, i_rready;
    logic [DATA_W-1:0] i_wdata, o_rdata, i_av_writedata, o_av_readdata;
    logic [RESP_W-1:0] o_bresp, o_rresp;
    logic [CSR_ADDR_W-1:0] i_av_address;
    logic i_av_write, i_av_read, o_irq;

    int errors = 0;
    int cycles = 0;
    // Reference logs hold {INFO, ID, ADDR, WDATA} per entry
    logic [127:0] ref_w [$];
    logic [127:0] ref_r [$];

    axi_err_slave dut_i (.*);

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    task automatic report_error(input string msg);
        errors++;
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    // INFO word with burst, len, size and prot above the valid bit
    function automatic logic [DATA_W-1:0] pack_info(input logic [PROT_W-1:0] prot,
            input logic [SIZE_W-1:0] size, input logic [LEN_W-1:0] len,
            input logic [BURST_W-1:0] burst);
        return {19'd0, burst, len, size, prot, 1'b1};
    endfunction

    // ------------------------------------------------
    // Protocol checks
    // ------------------------------------------------
    a_b_after_wlast: assert property (@(posedge aclk) disable iff (!aresetn)
        i_wvalid && o_wready && i_wlast |=> $rose(o_bvalid))
        else report_error("bvalid did not rise after the wlast transfer");
    a_r_after_ar: assert property (@(posedge aclk) disable iff (!aresetn)
        i_arvalid && o_arready |=> $rose(o_rvalid))
        else report_error("rvalid did not rise after the AR transfer");
    a_irq_wr: assert property (@(posedge aclk) disable iff (!aresetn)
        i_wvalid && o_wready && i_wlast |=> o_irq)
        else report_error("irq low one cycle after a write log load");
    a_irq_rd: assert property (@(posedge aclk) disable iff (!aresetn)
        i_arvalid && o_arready |=> o_irq)
        else report_error("irq low one cycle after a read log load");
    a_b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        o_bvalid && !i_bready |=> o_bvalid && $stable(o_bid) && $stable(o_bresp))
        else report_error("B channel changed while stalled");
    a_r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        o_rvalid && !i_rready |=> o_rvalid && $stable(o_rid) && $stable(o_rdata)
            && $stable(o_rlast) && $stable(o_rresp))
        else report_error("R channel changed while stalled");
    a_b_decerr: assert property (@(posedge aclk) disable iff (!aresetn)
        o_bvalid |-> o_bresp == RESP_DECERR)
        else report_error("bresp is not DECERR");
    a_r_decerr: assert property (@(posedge aclk) disable iff (!aresetn)
        o_rvalid |-> o_rresp == RESP_DECERR && o_rdata == '0)
        else report_error("rresp not DECERR or rdata not zero");
    a_rlast_valid: assert property (@(posedge aclk) disable iff (!aresetn)
        o_rlast |-> o_rvalid)
        else report_error("rlast high without rvalid");

    // ------------------------------------------------
    // Stimulus tasks start and end on a falling edge
    // ------------------------------------------------
    task automatic csr_read(input logic [CSR_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        i_av_address = addr;
        i_av_read    = 1'b1;
        @(negedge aclk);
        i_av_read = 1'b0;
        data      = o_av_readdata;
    endtask

    task automatic csr_write(input logic [CSR_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        i_av_address   = addr;
        i_av_writedata = data;
        i_av_write     = 1'b1;
        @(negedge aclk);
        i_av_write = 1'b0;
    endtask

    task automatic check_word(input string what, input logic [CSR_ADDR_W-1:0] addr,
            input logic [DATA_W-1:0] exp);
        logic [DATA_W-1:0] got;
        csr_read(addr, got);
        assert (got === exp)
            else report_error($sformatf("%s read 0x%08h, expected 0x%08h", what, got, exp));
    endtask

    task automatic axi_write();
        logic [ID_W-1:0] id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0] len;
        logic [SIZE_W-1:0] size;
        logic [BURST_W-1:0] burst;
        logic [PROT_W-1:0] prot;
        logic [DATA_W-1:0] data;
        bit done;
        id    = ID_W'($urandom);
        addr  = $urandom;
        len   = LEN_W'($urandom % 4);
        size  = SIZE_W'($urandom);
        burst = BURST_W'($urandom);
        prot  = PROT_W'($urandom);
        data  = '0;
        {i_awid, i_awaddr, i_awlen, i_awsize, i_awburst, i_awprot} =
            {id, addr, len, size, burst, prot};
        i_awvalid = 1'b1;
        while (!o_awready) @(negedge aclk);
        @(negedge aclk);
        i_awvalid = 1'b0;
        // Data beats back to back
        // Last beat's data goes into the log
        for (int beat = 0; beat <= int'(len); beat++) begin
            data     = $urandom;
            i_wdata  = data;
            i_wlast  = (beat == int'(len));
            i_wvalid = 1'b1;
            while (!o_wready) @(negedge aclk);
            @(negedge aclk);
        end
        i_wvalid = 1'b0;
        i_wlast  = 1'b0;
        if (ref_w.size() < LOG_DEPTH) begin
            ref_w.push_back({pack_info(prot, size, len, burst), 28'd0, id, addr, data});
        end
        // Response with random bready stalls
        done = 1'b0;
        while (!done) begin
            i_bready = ($urandom % 3) != 0;
            if (o_bvalid && i_bready) begin
                assert (o_bid === id)
                    else report_error($sformatf("bid 0x%0h, expected 0x%0h", o_bid, id));
                done = 1'b1;
            end
            @(negedge aclk);
        end
        i_bready = 1'b0;
        assert (!o_bvalid) else report_error("second B response after one write");
    endtask

    task automatic axi_read();
        logic [ID_W-1:0] id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0] len;
        logic [SIZE_W-1:0] size;
        logic [BURST_W-1:0] burst;
        logic [PROT_W-1:0] prot;
        int beat;
        bit done;
        id    = ID_W'($urandom);
        addr  = $urandom;
        len   = LEN_W'($urandom % 8);
        size  = SIZE_W'($urandom);
        burst = BURST_W'($urandom);
        prot  = PROT_W'($urandom);
        {i_arid, i_araddr, i_arlen, i_arsize, i_arburst, i_arprot} =
            {id, addr, len, size, burst, prot};
        i_arvalid = 1'b1;
        while (!o_arready) @(negedge aclk);
        @(negedge aclk);
        i_arvalid = 1'b0;
        if (ref_r.size() < LOG_DEPTH) begin
            ref_r.push_back({pack_info(prot, size, len, burst), 28'd0, id, addr, 32'd0});
        end
        beat = 0;
        done = 1'b0;
        while (!done) begin
            i_rready = ($urandom % 4) != 0;
            if (o_rvalid && i_rready) begin
                assert (o_rid === id)
                    else report_error($sformatf("rid 0x%0h, expected 0x%0h", o_rid, id));
                assert (o_rlast === (beat == int'(len)))
                    else report_error($sformatf("rlast wrong on beat %0d of %0d", beat, len));
                done = o_rlast || (beat == int'(len));
                beat++;
            end
            @(negedge aclk);
        end
        i_rready = 1'b0;
        assert (beat == int'(len) + 1)
            else report_error($sformatf("%0d R beats, expected %0d", beat, len + 1));
        assert (!o_rvalid) else report_error("extra R beat after rlast");
    endtask

    // Reads every logged entry in FIFO order, then expects an empty log
    task automatic drain_log(input bit is_read);
        logic [127:0] exp;
        int n;
        n = is_read ? ref_r.size() : ref_w.size();
        repeat (n) begin
            if (is_read) begin
                exp = ref_r.pop_front();
                check_word("R_INFO", CSR_R_INFO, exp[127:96]);
                check_word("R_ID", CSR_R_ID, exp[95:64]);
                check_word("R_ADDR", CSR_R_ADDR, exp[63:32]);
            end else begin
                exp = ref_w.pop_front();
                check_word("W_INFO", CSR_W_INFO, exp[127:96]);
                check_word("W_ID", CSR_W_ID, exp[95:64]);
                check_word("W_ADDR", CSR_W_ADDR, exp[63:32]);
                check_word("W_WDATA", CSR_W_WDATA, exp[31:0]);
            end
        end
        check_word("INFO of empty log", is_read ? CSR_R_INFO : CSR_W_INFO, '0);
    endtask

    task automatic clear_status();
        csr_write(CSR_INTR_STS, 32'hF);
        check_word("INTR_STS after clear", CSR_INTR_STS, '0);
        assert (!o_irq) else report_error("irq still high after status clear");
    endtask

    // ------------------------------------------------
    // Main sequence
    // ------------------------------------------------
    initial begin
        void'($urandom(SEED));
        aresetn   = 1'b0;
        {i_awid, i_awaddr, i_awlen, i_awsize, i_awburst, i_awprot, i_awvalid} = '0;
        {i_wdata, i_wlast, i_wvalid, i_bready} = '0;
        {i_arid, i_araddr, i_arlen, i_arsize, i_arburst, i_arprot, i_arvalid} = '0;
        i_rready = 1'b0;
        {i_av_address, i_av_write, i_av_read, i_av_writedata} = '0;
        repeat (4) @(negedge aclk);
        assert (!o_awready && !o_arready && !o_wready && !o_bvalid && !o_rvalid
                && !o_rlast && !o_irq)
            else report_error("outputs not idle during reset");
        aresetn = 1'b1;
        @(negedge aclk);
        // Address channels open on the first edge after reset
        assert (o_awready && o_arready)
            else report_error("awready or arready low in the first cycle after reset");

        // Plain errors per direction
        repeat (N_BASIC) axi_write();
        check_word("INTR_STS", CSR_INTR_STS, 32'd1 << INTR_WR);
        drain_log(1'b0);
        clear_status();
        repeat (N_BASIC) axi_read();
        check_word("INTR_STS", CSR_INTR_STS, 32'd1 << INTR_RD);
        drain_log(1'b1);
        clear_status();
        check_word("unmapped offset", 12'h0FC, '0);

        // Overflow keeps only the first LOG_DEPTH entries
        repeat (N_OVF) axi_write();
        check_word("INTR_STS", CSR_INTR_STS, (32'd1 << INTR_WR) | (32'd1 << INTR_WR_OVF));
        drain_log(1'b0);
        clear_status();
        repeat (N_OVF) axi_read();
        check_word("INTR_STS", CSR_INTR_STS, (32'd1 << INTR_RD) | (32'd1 << INTR_RD_OVF));
        drain_log(1'b1);
        clear_status();

        $display("Summary: %0d errors over %0d transactions", errors, NUM_TRANS);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Cycle limit
    initial begin
        while (cycles < TIMEOUT_CYC) begin
            @(posedge aclk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
        $display("Summary: %0d errors, run stopped by timeout", errors);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: list.f
design/err_resp_pkg.sv
design/err_log_if.sv
design/burst_beat_counter.sv
design/axi_err_resp_fsm.sv
design/err_log_fifo.sv
design/err_csr_bank.sv
design/axi_err_slave.sv
tests/tb_axi_err_slave.sv

// File: Bender.yml
package:
  name: axi_err_slave

sources:
  # Package and interface ahead of the modules that use them
  - design/err_resp_pkg.sv
  - design/err_log_if.sv
  - design/burst_beat_counter.sv
  - design/axi_err_resp_fsm.sv
  - design/err_log_fifo.sv
  - design/err_csr_bank.sv
  - design/axi_err_slave.sv
  - target: test
    files:
      - tests/tb_axi_err_slave.sv
